// ==== Makefile ====
# Verilator build for the decode and execute slice

VERILATOR ?= verilator
TOP       ?= rvDecodeExecTb
FILELIST  ?= filelist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0
SIM_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	-./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== filelist.f ====
rtl/rvCorePkg.sv
rtl/controlDecoder.sv
rtl/immExtend.sv
rtl/regFile.sv
rtl/executeUnit.sv
rtl/rvDecodeExec.sv
testbench/rvDecodeExec_props.sv
testbench/rvDecodeExecTb.sv

// ==== rtl/controlDecoder.sv ====
`default_nettype none

module controlDecoder import rvCorePkg::*; (
    input  wire logic [xlen-1:0] instr,
    output ctrl_t                ctrl
);

    logic [6:0] opcode;
    logic [2:0] funct3;

    assign opcode = instr[6:0];
    assign funct3 = instr[14:12];

    always_comb begin
        ctrl          = '0;
        ctrl.immFmt   = fmtI;          // harmless default for illegal words
        ctrl.rs1      = instr[19:15];  // register fields sit at fixed positions
        ctrl.rs2      = instr[24:20];
        ctrl.rd       = instr[11:7];

        case (opcode)
            opImm: begin
                if (funct3 == f3Addi) begin
                    ctrl.regWrite = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;  // other op-imm forms not supported
                end
            end
            opLoad: begin
                if (funct3 == f3Word) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.memRead  = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;  // no byte or halfword loads
                end
            end
            opStore: begin
                ctrl.immFmt = fmtS;
                if (funct3 == f3Word) begin
                    ctrl.memWrite = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            opBranch: begin
                ctrl.immFmt = fmtB;
                if (funct3 == f3Bne) begin
                    ctrl.isBranch = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;  // only bne
                end
            end
            opJal: begin
                ctrl.immFmt   = fmtJ;  // jal has no funct3
                ctrl.regWrite = 1'b1;
                ctrl.isJal    = 1'b1;
            end
            opJalr: begin
                if (funct3 == f3Addi) begin
                    ctrl.regWrite = 1'b1;
                    ctrl.isJalr   = 1'b1;
                end else begin
                    ctrl.illegal = 1'b1;
                end
            end
            default: begin
                ctrl.illegal = 1'b1;
            end
        endcase

        // the use flags are already clear on every illegal path
    end

endmodule

`default_nettype wire

// ==== rtl/executeUnit.sv ====
`default_nettype none

module executeUnit import rvCorePkg::*; (
    input  wire logic            instrValid,
    input  wire logic [xlen-1:0] pc,
    input  ctrl_t                ctrl,
    input  wire logic [xlen-1:0] imm,
    input  wire logic [xlen-1:0] rs1Data,
    input  wire logic [xlen-1:0] rs2Data,
    input  wire logic [xlen-1:0] loadData,
    output memReq_t              memReq,
    output regWrite_t            wr,
    output logic [xlen-1:0]      nextPc
);

    logic [xlen-1:0] rs1PlusImm;  // addi result, memory address, jalr target
    logic [xlen-1:0] pcPlus4;
    logic [xlen-1:0] pcPlusImm;   // jal and taken-branch target
    logic            operandsDiffer;
    logic            branchTaken;

    assign rs1PlusImm     = rs1Data + imm;
    assign pcPlus4        = pc + 32'd4;
    assign pcPlusImm      = pc + imm;
    assign operandsDiffer = (rs1Data != rs2Data);
    assign branchTaken    = ctrl.isBranch && operandsDiffer;

    // memory request, strobes only while the word is valid
    assign memReq.addr  = rs1PlusImm;
    assign memReq.wdata = rs2Data;
    assign memReq.read  = instrValid && ctrl.memRead;
    assign memReq.write = instrValid && ctrl.memWrite;

    assign wr.en   = instrValid && ctrl.regWrite;
    assign wr.addr = ctrl.rd;

    always_comb begin
        if (ctrl.memRead) begin
            wr.data = loadData;  // load data arrives the same cycle
        end else if (ctrl.isJal || ctrl.isJalr) begin
            wr.data = pcPlus4;   // link address
        end else begin
            wr.data = rs1PlusImm;
        end
    end

    // Next pc. An idle cycle holds pc; an illegal word steps over itself
    // like any other non-control-flow instruction.
    always_comb begin
        if (!instrValid) begin
            nextPc = pc;
        end else if (ctrl.isJal || branchTaken) begin
            nextPc = pcPlusImm;
        end else if (ctrl.isJalr) begin
            nextPc = {rs1PlusImm[xlen-1:1], 1'b0};  // target lsb cleared
        end else begin
            nextPc = pcPlus4;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/immExtend.sv ====
`default_nettype none

module immExtend import rvCorePkg::*; (
    input  wire logic [xlen-1:0] instr,
    input  immFmt_e              immFmt,
    output logic [xlen-1:0]      imm
);

    logic            signBit;
    logic [xlen-1:0] immI;
    logic [xlen-1:0] immS;
    logic [xlen-1:0] immB;
    logic [xlen-1:0] immJ;

    assign signBit = instr[31];  // every format takes its sign from bit 31

    // addi, lw and jalr
    assign immI = {{20{signBit}}, instr[31:20]};

    // store offset is split around the rd field
    assign immS = {{20{signBit}}, instr[31:25], instr[11:7]};

    assign immB = {
        {19{signBit}},
        instr[31],
        instr[7],       // imm[11]
        instr[30:25],
        instr[11:8],
        1'b0            // halfword aligned
    };

    assign immJ = {
        {11{signBit}},
        instr[31],
        instr[19:12],   // imm[19:12]
        instr[20],      // imm[11]
        instr[30:21],
        1'b0
    };

    always_comb begin
        case (immFmt)
            fmtI:    imm = immI;
            fmtS:    imm = immS;
            fmtB:    imm = immB;
            fmtJ:    imm = immJ;
            default: imm = immI;
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/regFile.sv ====
`default_nettype none

module regFile import rvCorePkg::*; (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic [4:0]      rs1,
    input  wire logic [4:0]      rs2,
    output logic [xlen-1:0]      rs1Data,
    output logic [xlen-1:0]      rs2Data,
    input  regWrite_t            wr
);

    logic [xlen-1:0] regs [1:31];  // x0 has no storage

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.en && (wr.addr != 5'd0)) begin
            regs[wr.addr] <= wr.data;  // writes to x0 fall through
        end
    end

    // combinational reads, x0 hardwired to zero
    always_comb begin
        if (rs1 == 5'd0) begin
            rs1Data = '0;
        end else begin
            rs1Data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == 5'd0) begin
            rs2Data = '0;
        end else begin
            rs2Data = regs[rs2];
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rvCorePkg.sv ====
`default_nettype none

package rvCorePkg;

    localparam int xlen = 32;  // data and address width

    // major opcodes of the supported subset
    localparam logic [6:0] opImm    = 7'd19;   // addi
    localparam logic [6:0] opLoad   = 7'd3;    // lw
    localparam logic [6:0] opStore  = 7'd35;   // sw
    localparam logic [6:0] opBranch = 7'd99;   // bne
    localparam logic [6:0] opJal    = 7'd111;
    localparam logic [6:0] opJalr   = 7'd103;

    localparam logic [2:0] f3Addi = 3'd0;  // also the jalr funct3
    localparam logic [2:0] f3Word = 3'd2;  // lw and sw
    localparam logic [2:0] f3Bne  = 3'd1;

    // immediate layouts, picked by the decoder
    typedef enum logic [1:0] {
        fmtI = 2'd0,  // addi, lw, jalr
        fmtS = 2'd1,  // sw
        fmtB = 2'd2,  // bne
        fmtJ = 2'd3   // jal
    } immFmt_e;

    typedef struct packed {
        immFmt_e    immFmt;
        logic       regWrite;   // rd gets a write-back value
        logic       memRead;
        logic       memWrite;
        logic       isBranch;   // bne
        logic       isJal;
        logic       isJalr;
        logic       illegal;    // opcode or funct3 outside the subset
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [4:0] rd;
    } ctrl_t;

    // data-memory request, answered in the same cycle
    typedef struct packed {
        logic [xlen-1:0] addr;
        logic [xlen-1:0] wdata;
        logic            read;
        logic            write;
    } memReq_t;

    typedef struct packed {
        logic            en;
        logic [4:0]      addr;  // x0 is dropped by the register file
        logic [xlen-1:0] data;
    } regWrite_t;

endpackage

`default_nettype wire

// ==== rtl/rvDecodeExec.sv ====
`default_nettype none

module rvDecodeExec import rvCorePkg::*; (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic            instrValid,
    input  wire logic [xlen-1:0] instr,
    input  wire logic [xlen-1:0] pc,
    input  wire logic [xlen-1:0] loadData,
    output memReq_t              memReq,
    output logic [xlen-1:0]      nextPc,
    output logic                 illegal
);

    ctrl_t           ctrl;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] rs1Data;
    logic [xlen-1:0] rs2Data;
    regWrite_t       wr;

    controlDecoder i_controlDecoder (
        .instr (instr),
        .ctrl  (ctrl)
    );

    immExtend i_immExtend (
        .instr  (instr),
        .immFmt (ctrl.immFmt),
        .imm    (imm)
    );

    regFile i_regFile (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (ctrl.rs1),
        .rs2     (ctrl.rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wr      (wr)
    );

    executeUnit i_executeUnit (
        .instrValid (instrValid),
        .pc         (pc),
        .ctrl       (ctrl),
        .imm        (imm),
        .rs1Data    (rs1Data),
        .rs2Data    (rs2Data),
        .loadData   (loadData),
        .memReq     (memReq),
        .wr         (wr),
        .nextPc     (nextPc)
    );

    assign illegal = instrValid && ctrl.illegal;  // flagged only for a valid word

endmodule

`default_nettype wire

// ==== testbench/rvDecodeExecTb.sv ====
`default_nettype none

module rvDecodeExecTb import rvCorePkg::*; ();

    localparam int clkPeriod   = 8;
    localparam int resetCycles = 16;
    localparam int testCycles  = 80;   // about 75 instruction and idle cycles over all tests
    localparam int margin      = 200;

    logic            clk;
    logic            rstN;
    logic            instrValid;
    logic [xlen-1:0] instr;
    logic [xlen-1:0] pc;
    logic [xlen-1:0] loadData;
    memReq_t         memReq;
    logic [xlen-1:0] nextPc;
    logic            illegal;

    logic [xlen-1:0] model [0:31];   // register model
    logic [xlen-1:0] mem [0:255];    // word-addressed data memory
    logic            expRead;
    logic            expWrite;
    logic            expIllegal;
    logic [xlen-1:0] expAddr;
    logic [xlen-1:0] expWdata;
    logic [xlen-1:0] expNextPc;
    logic            wbEn;           // pending model write at the next edge
    logic [4:0]      wbRd;
    logic [xlen-1:0] wbData;
    logic [xlen-1:0] pcVal;
    logic [31:0]     lcgState;
    int              errors = 0;
    int              testErrors = 0;
    int              testsRun = 0;

    rvDecodeExec i_dut (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .pc         (pc),
        .loadData   (loadData),
        .memReq     (memReq),
        .nextPc     (nextPc),
        .illegal    (illegal)
    );

    bind rvDecodeExec rvDecodeExecProps i_props (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .pc         (pc),
        .memReq     (memReq),
        .nextPc     (nextPc),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #(clkPeriod / 2) clk = ~clk;
    end

    // memory answers in the same cycle
    always_comb begin
        if (memReq.read) begin
            loadData = mem[memReq.addr[9:2]];
        end else begin
            loadData = '0;
        end
    end

    task automatic reportMismatch(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
        $display("[FAIL] %s expected %h got %h", name, expected, actual);
        errors++;
    endtask

    readMatches: assert property (@(posedge clk) disable iff (!rstN)
            memReq.read == expRead)
        else reportMismatch("memReq.read", 32'($sampled(expRead)), 32'($sampled(memReq.read)));
    writeMatches: assert property (@(posedge clk) disable iff (!rstN)
            memReq.write == expWrite)
        else reportMismatch("memReq.write", 32'($sampled(expWrite)),
                            32'($sampled(memReq.write)));
    addrMatches: assert property (@(posedge clk) disable iff (!rstN)
            (expRead || expWrite) |-> (memReq.addr == expAddr))
        else reportMismatch("memReq.addr", $sampled(expAddr), $sampled(memReq.addr));
    wdataMatches: assert property (@(posedge clk) disable iff (!rstN)
            expWrite |-> (memReq.wdata == expWdata))
        else reportMismatch("memReq.wdata", $sampled(expWdata), $sampled(memReq.wdata));
    nextPcMatches: assert property (@(posedge clk) disable iff (!rstN)
            nextPc == expNextPc)
        else reportMismatch("nextPc", $sampled(expNextPc), $sampled(nextPc));
    illegalMatches: assert property (@(posedge clk) disable iff (!rstN)
            illegal == expIllegal)
        else reportMismatch("illegal", 32'($sampled(expIllegal)), 32'($sampled(illegal)));

    function automatic logic [31:0] nextRand();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int randBelow(input int n);
        logic [31:0] r;
        r = nextRand();
        return int'({17'd0, r[30:16]}) % n;  // upper bits, low ones are weak
    endfunction

    function automatic logic [31:0] randImm12();
        logic [31:0] r;
        r = nextRand();
        return {{20{r[27]}}, r[27:16]};
    endfunction

    function automatic logic [31:0] randJImm();
        logic [31:0] r;
        r = nextRand();
        return {{11{r[30]}}, r[30:11], 1'b0};
    endfunction

    // encoders, imm given as its signed 32-bit value
    function automatic logic [31:0] encI(input logic [6:0] op, input logic [2:0] f3,
                                        input logic [4:0] rd, input logic [4:0] rs1,
                                        input logic [31:0] imm);
        return {imm[11:0], rs1, f3, rd, op};
    endfunction

    function automatic logic [31:0] encS(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], opStore};
    endfunction

    function automatic logic [31:0] encB(input logic [2:0] f3, input logic [4:0] rs1,
                                        input logic [4:0] rs2, input logic [31:0] imm);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], opBranch};
    endfunction

    function automatic logic [31:0] encJ(input logic [4:0] rd, input logic [31:0] imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, opJal};
    endfunction

    task automatic setExp(input logic read, input logic write, input logic ill,
                          input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [31:0] npc, input logic wbE, input logic [4:0] wbR,
                          input logic [31:0] wbD);
        expRead    = read;
        expWrite   = write;
        expIllegal = ill;
        expAddr    = addr;
        expWdata   = wdata;
        expNextPc  = npc;
        wbEn       = wbE;
        wbRd       = wbR;
        wbData     = wbD;
    endtask

    // one valid instruction, models follow at the edge
    task automatic issue(input logic [31:0] word);
        instr      = word;
        instrValid = 1'b1;
        pc         = pcVal;
        @(posedge clk);
        if (wbEn && (wbRd != 5'd0)) begin
            model[wbRd] = wbData;
        end
        if (expWrite) begin
            mem[expAddr[9:2]] = expWdata;
        end
        pcVal = expNextPc;
        #1;
    endtask

    task automatic idle(input logic [31:0] word);
        setExp(1'b0, 1'b0, 1'b0, '0, '0, pcVal, 1'b0, 5'd0, '0);
        instr      = word;
        instrValid = 1'b0;
        pc         = pcVal;
        @(posedge clk);
        #1;
    endtask

    task automatic doAddi(input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
        setExp(1'b0, 1'b0, 1'b0, '0, '0, pcVal + 32'd4, 1'b1, rd, model[rs1] + imm);
        issue(encI(opImm, f3Addi, rd, rs1, imm));
    endtask

    task automatic doLw(input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
        logic [31:0] addr;
        addr = model[rs1] + imm;
        setExp(1'b1, 1'b0, 1'b0, addr, '0, pcVal + 32'd4, 1'b1, rd, mem[addr[9:2]]);
        issue(encI(opLoad, f3Word, rd, rs1, imm));
    endtask

    task automatic doSw(input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
        setExp(1'b0, 1'b1, 1'b0, model[rs1] + imm, model[rs2], pcVal + 32'd4, 1'b0, 5'd0, '0);
        issue(encS(f3Word, rs1, rs2, imm));
    endtask

    task automatic doBne(input logic [4:0] rs1, input logic [4:0] rs2, input logic [31:0] imm);
        logic [31:0] npc;
        npc = (model[rs1] != model[rs2]) ? pcVal + imm : pcVal + 32'd4;
        setExp(1'b0, 1'b0, 1'b0, '0, '0, npc, 1'b0, 5'd0, '0);
        issue(encB(f3Bne, rs1, rs2, imm));
    endtask

    task automatic doJal(input logic [4:0] rd, input logic [31:0] imm);
        setExp(1'b0, 1'b0, 1'b0, '0, '0, pcVal + imm, 1'b1, rd, pcVal + 32'd4);
        issue(encJ(rd, imm));
    endtask

    task automatic doJalr(input logic [4:0] rd, input logic [4:0] rs1, input logic [31:0] imm);
        logic [31:0] target;
        target = model[rs1] + imm;
        setExp(1'b0, 1'b0, 1'b0, '0, '0, {target[31:1], 1'b0}, 1'b1, rd, pcVal + 32'd4);
        issue(encI(opJalr, f3Addi, rd, rs1, imm));
    endtask

    task automatic doIllegal(input logic [31:0] word);
        setExp(1'b0, 1'b0, 1'b1, '0, '0, pcVal + 32'd4, 1'b0, 5'd0, '0);
        issue(word);
    endtask

    task automatic endTest(input string name);
        idle(encI(opImm, f3Addi, 5'd0, 5'd0, '0));  // idle cycle between tests
        $display("%-18s %0d failing checks", name, errors - testErrors);
        testErrors = errors;
        testsRun++;
    endtask

    initial begin
        logic [4:0]  rd;
        logic [31:0] imm;
        int          total;
        instrValid = 1'b0;
        instr      = '0;
        pc         = '0;
        rstN       = 1'b0;
        setExp(1'b0, 1'b0, 1'b0, '0, '0, '0, 1'b0, 5'd0, '0);
        lcgState   = 32'd93914;
        pcVal      = 32'h0000_1000;
        for (int i = 0; i < 32; i++) begin
            model[i] = '0;
        end
        for (int i = 0; i < 256; i++) begin
            mem[i] = (32'(i) * 32'h9E37_79B1) ^ 32'h0F0F_0F0F;
        end
        repeat (resetCycles) @(posedge clk);
        #1 rstN = 1'b1;

        for (int i = 0; i < 6; i++) begin
            rd = 5'(1 + randBelow(15));
            doAddi(rd, 5'(randBelow(16)), randImm12());
            doSw(5'd0, rd, 32'h100 + 32'(4 * i));
        end
        doAddi(5'd0, 5'd3, 32'd5);  // x0 stays zero
        doSw(5'd0, 5'd0, 32'h120);
        endTest("addi chain");

        doAddi(5'd20, 5'd0, 32'h200);  // base pointer
        for (int i = 0; i < 4; i++) begin
            imm = 32'((randBelow(32) - 16) * 4);
            doAddi(5'd21, 5'd0, randImm12());
            doSw(5'd20, 5'd21, imm);
            doLw(5'd22, 5'd20, imm);
            doSw(5'd20, 5'd22, imm + 32'd4);
        end
        doLw(5'd23, 5'd20, 32'h80);  // untouched word, fill pattern
        doSw(5'd0, 5'd23, 32'h80);
        endTest("load and store");

        doAddi(5'd6, 5'd0, randImm12());
        doAddi(5'd7, 5'd6, 32'd1);
        for (int i = 0; i < 6; i++) begin
            doBne(5'd6, (i % 2 == 0) ? 5'd7 : 5'd6, randImm12() << 1);
        end
        doBne(5'd6, 5'd7, 32'hFFFF_FFF0);
        endTest("bne");

        for (int i = 0; i < 3; i++) begin
            doJal(5'd8, randJImm());
            doSw(5'd0, 5'd8, 32'h140);
            doJalr(5'd9, 5'd6, randImm12());
            doSw(5'd0, 5'd9, 32'h144);
        end
        doJalr(5'd6, 5'd6, model[6][0] ? 32'd2 : 32'd3);  // odd target, rd equals rs1
        doSw(5'd0, 5'd6, 32'h148);
        endTest("jal and jalr");

        doIllegal(encI(7'h33, 3'd0, 5'd3, 5'd1, '0));
        doIllegal(encI(opLoad, 3'd0, 5'd4, 5'd20, '0));
        doIllegal(encS(3'd1, 5'd20, 5'd21, '0));
        doIllegal(encB(3'd0, 5'd6, 5'd7, 32'd16));
        doIllegal(encI(opImm, 3'd1, 5'd5, 5'd6, 32'd1));
        doIllegal(encI(opJalr, 3'd1, 5'd8, 5'd6, '0));
        doSw(5'd0, 5'd4, 32'h14C);
        doSw(5'd0, 5'd5, 32'h150);
        idle(encS(f3Word, 5'd20, 5'd21, '0));
        idle(encI(opImm, f3Addi, 5'd21, 5'd0, 32'h7FF));
        idle(encJ(5'd21, 32'd64));
        doSw(5'd20, 5'd21, '0);  // x21 kept its value
        endTest("illegal and idle");

        total = errors + i_dut.i_props.failCount;
        $display("tests run %0d, failing checks %0d", testsRun, total);
        if (total == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        #((resetCycles + 2 * testCycles) * clkPeriod + margin);
        $display("timeout: tests did not finish within %0d cycles",
                 resetCycles + 2 * testCycles);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/rvDecodeExec_props.sv ====
`default_nettype none

module rvDecodeExecProps import rvCorePkg::*; (
    input  wire logic            clk,
    input  wire logic            rstN,
    input  wire logic            instrValid,
    input  wire logic [xlen-1:0] pc,
    input  memReq_t              memReq,
    input  wire logic [xlen-1:0] nextPc,
    input  wire logic            illegal
);

    int failCount = 0;  // read by the testbench at the end

    oneAccess: assert property (@(posedge clk) disable iff (!rstN)
            !(memReq.read && memReq.write))
        else begin
            $error("memory read and write requested in the same cycle");
            failCount++;
        end

    // stalled cycles touch nothing
    idleQuiet: assert property (@(posedge clk) disable iff (!rstN)
            !instrValid |-> (!memReq.read && !memReq.write && !illegal))
        else begin
            $error("memory access or illegal flag while instrValid is low");
            failCount++;
        end

    idleHoldsPc: assert property (@(posedge clk) disable iff (!rstN)
            !instrValid |-> (nextPc == pc))
        else begin
            $error("nextPc differs from pc while instrValid is low");
            failCount++;
        end

    resetQuiet: assert property (@(posedge clk)
            !rstN |-> (!memReq.read && !memReq.write))
        else begin
            $error("memory access during reset");
            failCount++;
        end

endmodule

`default_nettype wire
